/* nocXbar.f */
source/nocChanPkg.sv
source/xbarCfgPkg.sv
source/xbarCfgIf.sv
source/cfgRegBank.sv
source/outputPlane.sv
source/ackReturn.sv
source/dcbXy.sv
test/tbClkGen.sv
test/dcbXy_assert.sv
test/tbDcbXy.sv

/* test/tbDcbXy.sv */
`timescale 1ns/1ps

module tbDcbXy;

   localparam int Ports     = nocChanPkg::PortCount;
   localparam int RowCount  = 10;
   localparam int WaitLimit = 20;   // cycles allowed per wait

   typedef struct {
      nocChanPkg::portT     outPort;
      nocChanPkg::portT     srcPort;
      logic                 connect;
      logic                 eof;       // driven on srcPort
      logic                 ack;       // driven on outPort
      nocChanPkg::chanDataT data;      // driven on srcPort
   } rowT;

   logic                             clk;
   logic                             rst;
   nocChanPkg::chanDataT [Ports-1:0] inData;
   logic [Ports-1:0]                 inEof;
   logic [Ports-1:0]                 inAck;
   nocChanPkg::chanDataT [Ports-1:0] outData;
   logic [Ports-1:0]                 outEof;
   logic [Ports-1:0]                 outAck;
   logic                             cfgReq;
   nocChanPkg::portT                 cfgOut;
   nocChanPkg::portT                 cfgSrc;
   logic                             cfgConnect;
   logic                             cfgAck;

   rowT              rows [RowCount];
   logic [Ports-1:0] modelSel [Ports];   // expected one-hot source per output
   int               seed         = 36;
   int               errorCount   = 0;
   int               checkCount   = 0;
   int               timeoutCount = 0;

   tbClkGen clkGen (
      .clk (clk),
      .rst (rst)
   );

   dcbXy i_dcbXy (
      .clk        (clk),
      .rst        (rst),
      .inData     (inData),
      .inEof      (inEof),
      .inAck      (inAck),
      .outData    (outData),
      .outEof     (outEof),
      .outAck     (outAck),
      .cfgReq     (cfgReq),
      .cfgOut     (cfgOut),
      .cfgSrc     (cfgSrc),
      .cfgConnect (cfgConnect),
      .cfgAck     (cfgAck)
   );

   // XY routing, listed per output
   function automatic logic legalTurn(input nocChanPkg::portT outP,
                                      input nocChanPkg::portT srcP);
      case (outP)
         nocChanPkg::South: return (srcP == nocChanPkg::North) || (srcP == nocChanPkg::Local);
         nocChanPkg::North: return (srcP == nocChanPkg::South) || (srcP == nocChanPkg::Local);
         nocChanPkg::West:  return srcP != nocChanPkg::West;
         nocChanPkg::East:  return srcP != nocChanPkg::East;
         default:           return srcP != nocChanPkg::Local;
      endcase
   endfunction

   function automatic logic [Ports-1:0] expectedSel(input nocChanPkg::portT outP,
                                                    input nocChanPkg::portT srcP,
                                                    input logic connect);
      logic [Ports-1:0] sel;
      sel = '0;
      if (connect && legalTurn(outP, srcP)) begin
         sel[srcP] = 1'b1;
      end
      return sel;
   endfunction

   // one-hot symbol in every sub-channel
   function automatic nocChanPkg::chanDataT randomChan();
      nocChanPkg::chanDataT d;
      for (int k = 0; k < nocChanPkg::SubChanCount; k++) begin
         d[k] = 4'b0001 << ($unsigned($random(seed)) % 4);
      end
      return d;
   endfunction

   task automatic checkValue(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
      checkCount++;
      if (actual !== expected) begin
         errorCount++;
         $display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
      end
   endtask

   task automatic fillTable();
      rows[0] = '{nocChanPkg::Local, nocChanPkg::South, 1'b1, 1'b1, 1'b1, '0};
      rows[1] = '{nocChanPkg::West,  nocChanPkg::East,  1'b1, 1'b0, 1'b1, '0};
      rows[2] = '{nocChanPkg::South, nocChanPkg::West,  1'b1, 1'b1, 1'b1, '0};  // forbidden
      rows[3] = '{nocChanPkg::North, nocChanPkg::East,  1'b1, 1'b1, 1'b1, '0};  // forbidden
      rows[4] = '{nocChanPkg::East,  nocChanPkg::South, 1'b1, 1'b1, 1'b1, '0};  // multicast
      rows[5] = '{nocChanPkg::North, nocChanPkg::South, 1'b1, 1'b0, 1'b0, '0};
      rows[6] = '{nocChanPkg::South, nocChanPkg::North, 1'b1, 1'b1, 1'b1, '0};
      rows[7] = '{nocChanPkg::Local, nocChanPkg::South, 1'b0, 1'b1, 1'b1, '0};  // disconnect
      rows[8] = '{nocChanPkg::West,  nocChanPkg::Local, 1'b1, 1'b1, 1'b0, '0};
      rows[9] = '{nocChanPkg::East,  nocChanPkg::East,  1'b1, 1'b1, 1'b1, '0};  // u-turn
      for (int r = 0; r < RowCount; r++) begin
         rows[r].data = randomChan();
      end
   endtask

   task automatic randomizeInputs();
      for (int p = 0; p < Ports; p++) begin
         inData[p] = randomChan();
         inEof[p]  = ($random(seed) & 1) != 0;
      end
   endtask

   // compare all outputs and upstream acks against the model
   task automatic checkOutputs(input string tag);
      nocChanPkg::chanDataT expData;
      logic                 expEof;
      logic                 expAck;
      for (int o = 0; o < Ports; o++) begin
         expData = '0;
         expEof  = 1'b0;
         for (int s = 0; s < Ports; s++) begin
            if (modelSel[o][s]) begin
               expData = inData[s];
               expEof  = inEof[s];
            end
         end
         checkValue($sformatf("%s outData[%0d]", tag, o), expData, outData[o]);
         checkValue($sformatf("%s outEof[%0d]", tag, o), expEof, outEof[o]);
      end
      for (int i = 0; i < Ports; i++) begin
         expAck = 1'b0;
         for (int o = 0; o < Ports; o++) begin
            expAck = expAck | (outAck[o] & modelSel[o][i]);
         end
         checkValue($sformatf("%s inAck[%0d]", tag, i), expAck, inAck[i]);
      end
   endtask

   task automatic waitReset(output logic ok);
      int count;
      count = 0;
      while (rst && count < WaitLimit) begin
         @(negedge clk);
         count++;
      end
      ok = !rst;
      if (!ok) begin
         timeoutCount++;
         $display("Timeout: reset was not released within %0d cycles", WaitLimit);
      end
   endtask

   // four-phase write, entered on a falling edge
   task automatic configure(input nocChanPkg::portT outP, input nocChanPkg::portT srcP,
                            input logic connect, output logic ok);
      int count;
      ok = 1'b1;
      checkValue("cfgAck before request", 1'b0, cfgAck);
      cfgOut     = outP;
      cfgSrc     = srcP;
      cfgConnect = connect;
      cfgReq     = 1'b1;
      count      = 0;
      while (!cfgAck && count < WaitLimit) begin
         @(negedge clk);
         count++;
      end
      cfgReq = 1'b0;   // ack seen, or given up
      if (!cfgAck) begin
         ok = 1'b0;
         timeoutCount++;
         $display("Timeout: cfgAck did not rise within %0d cycles", WaitLimit);
      end else begin
         count = 0;
         while (cfgAck && count < WaitLimit) begin
            @(negedge clk);
            count++;
         end
         if (cfgAck) begin
            ok = 1'b0;
            timeoutCount++;
            $display("Timeout: cfgAck did not fall within %0d cycles", WaitLimit);
         end
      end
   endtask

   task automatic applyRow(input int r, output logic ok);
      string tag;
      tag = $sformatf("row %0d", r);
      @(negedge clk);
      randomizeInputs();
      inData[rows[r].srcPort] = rows[r].data;
      inEof[rows[r].srcPort]  = rows[r].eof;
      outAck                  = '0;
      configure(rows[r].outPort, rows[r].srcPort, rows[r].connect, ok);
      if (ok) begin
         modelSel[rows[r].outPort] = expectedSel(rows[r].outPort, rows[r].srcPort,
                                                 rows[r].connect);
         outAck[rows[r].outPort] = rows[r].ack;   // at a falling edge already
         @(posedge clk);
         checkOutputs({tag, " row ack"});
         @(negedge clk);
         randomizeInputs();
         outAck = Ports'($random(seed));
         @(posedge clk);
         checkOutputs({tag, " random acks"});
         @(negedge clk);
         outAck = '1;   // every multicast source sees its OR
         @(posedge clk);
         checkOutputs({tag, " all acks"});
      end
   endtask

   initial begin
      logic ok;
      inData     = '0;
      inEof      = '0;
      outAck     = '0;
      cfgReq     = 1'b0;
      cfgOut     = nocChanPkg::South;
      cfgSrc     = nocChanPkg::South;
      cfgConnect = 1'b0;
      for (int o = 0; o < Ports; o++) begin
         modelSel[o] = '0;
      end
      fillTable();

      waitReset(ok);
      if (ok) begin
         // nothing connected yet, busy inputs must not leak through
         @(negedge clk);
         randomizeInputs();
         outAck = '1;
         @(posedge clk);
         checkOutputs("after reset");
         checkValue("after reset cfgAck", 1'b0, cfgAck);
         for (int r = 0; r < RowCount && ok; r++) begin
            applyRow(r, ok);
         end
      end

      $display("Checks: %0d, errors: %0d, timeouts: %0d, assertion failures: %0d",
               checkCount, errorCount, timeoutCount, i_dcbXy.checkAssert.assertFails);
      if (errorCount == 0 && timeoutCount == 0 && i_dcbXy.checkAssert.assertFails == 0) begin
         $display("All tests passed!");
      end else begin
         $display("Test failures found");
      end
      $finish;
   end

endmodule

/* test/dcbXy_assert.sv */
`timescale 1ns/1ps

module dcbXyAssert (
   input logic clk,
   input logic rst,
   input logic cfgReq,
   input logic cfgAck
);

   int assertFails = 0;   // failure count for the closing report

   // ack cleared by reset
   ackLowInReset: assert property (@(posedge clk) rst |=> !cfgAck)
      else begin
         assertFails++;
         $error("cfgAck is high although reset was asserted");
      end

   // rising ack needs a pending request
   ackRiseNeedsReq: assert property (@(posedge clk) disable iff (rst)
      $rose(cfgAck) |-> $past(cfgReq))
      else begin
         assertFails++;
         $error("cfgAck rose without cfgReq being high");
      end

   // return to zero only once the request is gone
   ackFallNeedsRelease: assert property (@(posedge clk) disable iff (rst)
      $fell(cfgAck) |-> !$past(cfgReq))
      else begin
         assertFails++;
         $error("cfgAck fell while cfgReq was still high");
      end

endmodule

bind dcbXy dcbXyAssert checkAssert (
   .clk    (clk),
   .rst    (rst),
   .cfgReq (cfgReq),
   .cfgAck (cfgAck)
);

/* test/tbClkGen.sv */
`timescale 1ns/1ps

module tbClkGen (
   output logic clk,
   output logic rst
);

   localparam time HalfPeriod = 10ns;   // 20 ns clock

   initial begin
      clk = 1'b0;
      forever #HalfPeriod clk = ~clk;
   end

   // two rising edges in reset, released on a falling edge
   initial begin
      rst = 1'b1;
      repeat (2) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;
   end

endmodule

/* source/dcbXy.sv */
`timescale 1ns/1ps

module dcbXy (
   input  logic clk,
   input  logic rst,

   // input side
   input  nocChanPkg::chanDataT [nocChanPkg::PortCount-1:0] inData,
   input  logic [nocChanPkg::PortCount-1:0]                 inEof,
   output logic [nocChanPkg::PortCount-1:0]                 inAck,   // back upstream

   // output side
   output nocChanPkg::chanDataT [nocChanPkg::PortCount-1:0] outData,
   output logic [nocChanPkg::PortCount-1:0]                 outEof,
   input  logic [nocChanPkg::PortCount-1:0]                 outAck,  // from downstream

   // configuration port, four-phase
   input  logic                                             cfgReq,
   input  nocChanPkg::portT                                 cfgOut,
   input  nocChanPkg::portT                                 cfgSrc,
   input  logic                                             cfgConnect,
   output logic                                             cfgAck
);

   xbarCfgIf cfgBus ();   // stored selections

   cfgRegBank regBank (
      .clk        (clk),
      .rst        (rst),
      .cfgReq     (cfgReq),
      .cfgOut     (cfgOut),
      .cfgSrc     (cfgSrc),
      .cfgConnect (cfgConnect),
      .cfgAck     (cfgAck),
      .cfg        (cfgBus.owner)
   );

   // one data plane per output port
   for (genvar p = 0; p < nocChanPkg::PortCount; p++) begin : gPlane
      outputPlane #(
         .OutPort (nocChanPkg::portT'(p))
      ) plane (
         .inData  (inData),
         .inEof   (inEof),
         .cfg     (cfgBus.user),
         .outData (outData[p]),
         .outEof  (outEof[p])
      );
   end

   ackReturn ackPath (
      .outAck (outAck),
      .cfg    (cfgBus.user),
      .inAck  (inAck)
   );

endmodule

/* source/ackReturn.sv */
`timescale 1ns/1ps

module ackReturn (
   input  logic [nocChanPkg::PortCount-1:0] outAck,   // from downstream, per output
   xbarCfgIf.user                           cfg,
   output logic [nocChanPkg::PortCount-1:0] inAck     // to upstream, per input
);

   // selections gathered by output index
   xbarCfgPkg::srcSelT [nocChanPkg::PortCount-1:0] selByOut;

   // ack terms, [input][output]
   logic [nocChanPkg::PortCount-1:0][nocChanPkg::PortCount-1:0] ackTerm;

   assign selByOut[nocChanPkg::South] = cfg.sSel;
   assign selByOut[nocChanPkg::West]  = cfg.wSel;
   assign selByOut[nocChanPkg::North] = cfg.nSel;
   assign selByOut[nocChanPkg::East]  = cfg.eSel;
   assign selByOut[nocChanPkg::Local] = cfg.lSel;

   // shuffle of output acks back onto their sources
   for (genvar i = 0; i < nocChanPkg::PortCount; i++) begin : gIn
      for (genvar o = 0; o < nocChanPkg::PortCount; o++) begin : gOut
         if (xbarCfgPkg::TurnAllowed[o][i]) begin : gTurn
            assign ackTerm[i][o] = outAck[o] & selByOut[o][i];
         end else begin : gCut
            assign ackTerm[i][o] = 1'b0;   // turn never exists
         end
      end

      // multicast source sees the OR of its outputs
      assign inAck[i] = |ackTerm[i];
   end

endmodule

/* source/outputPlane.sv */
`timescale 1ns/1ps

module outputPlane #(
   parameter nocChanPkg::portT OutPort = nocChanPkg::South   // output driven here
) (
   input  nocChanPkg::chanDataT [nocChanPkg::PortCount-1:0] inData,
   input  logic [nocChanPkg::PortCount-1:0]                 inEof,
   xbarCfgIf.user                                           cfg,
   output nocChanPkg::chanDataT                             outData,
   output logic                                             outEof
);

   // sources this output may ever take, fixed at elaboration
   localparam xbarCfgPkg::srcSelT Legal = xbarCfgPkg::TurnAllowed[OutPort];

   xbarCfgPkg::srcSelT                             sel;
   nocChanPkg::chanDataT [nocChanPkg::PortCount-1:0] gatedData;   // per source
   logic [nocChanPkg::PortCount-1:0]               gatedEof;

   // own selection out of the bundle
   always_comb begin
      case (OutPort)
         nocChanPkg::South: sel = cfg.sSel;
         nocChanPkg::West:  sel = cfg.wSel;
         nocChanPkg::North: sel = cfg.nSel;
         nocChanPkg::East:  sel = cfg.eSel;
         default:           sel = cfg.lSel;
      endcase
   end

   // AND stage, forbidden turns get no gate
   for (genvar s = 0; s < nocChanPkg::PortCount; s++) begin : gSrc
      if (Legal[s]) begin : gTurn
         for (genvar k = 0; k < nocChanPkg::SubChanCount; k++) begin : gSub
            assign gatedData[s][k] = inData[s][k] & {nocChanPkg::RailCount{sel[s]}};
         end
         assign gatedEof[s] = inEof[s] & sel[s];
      end else begin : gCut
         assign gatedData[s] = '0;
         assign gatedEof[s]  = 1'b0;
      end
   end

   // OR stage across sources, zero when disconnected
   always_comb begin
      outData = '0;
      outEof  = 1'b0;
      for (int s = 0; s < nocChanPkg::PortCount; s++) begin
         outData = outData | gatedData[s];
         outEof  = outEof | gatedEof[s];
      end
   end

endmodule

/* source/cfgRegBank.sv */
`timescale 1ns/1ps

module cfgRegBank (
   input  logic             clk,
   input  logic             rst,
   input  logic             cfgReq,       // four-phase request
   input  nocChanPkg::portT cfgOut,       // output being configured
   input  nocChanPkg::portT cfgSrc,       // requested source
   input  logic             cfgConnect,   // clear to disconnect
   output logic             cfgAck,
   xbarCfgIf.owner          cfg
);

   xbarCfgPkg::cfgStateT state;
   xbarCfgPkg::cfgStateT nextState;

   // one selection per output, indexed by portT
   xbarCfgPkg::srcSelT [nocChanPkg::PortCount-1:0] selReg;
   xbarCfgPkg::srcSelT                             newSel;

   // turn check, illegal turns collapse to disconnected
   assign newSel = xbarCfgPkg::turnCode(cfgOut, cfgSrc, cfgConnect);

   // handshake sequencing
   always_comb begin
      nextState = state;
      case (state)
         xbarCfgPkg::Idle: begin
            if (cfgReq) begin
               nextState = xbarCfgPkg::Write;   // request seen, fields stable
            end
         end
         xbarCfgPkg::Write: begin
            nextState = xbarCfgPkg::WaitRelease;   // register loads, ack rises
         end
         xbarCfgPkg::WaitRelease: begin
            if (!cfgReq) begin
               nextState = xbarCfgPkg::Idle;   // return to zero phase
            end
         end
         default: begin
            nextState = xbarCfgPkg::Idle;
         end
      endcase
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         state <= xbarCfgPkg::Idle;
      end else begin
         state <= nextState;
      end
   end

   // only the addressed output changes
   always_ff @(posedge clk) begin
      if (rst) begin
         selReg <= '0;   // all outputs disconnected
      end else if (state == xbarCfgPkg::Write) begin
         selReg[cfgOut] <= newSel;
      end
   end

   // ack and the new selection appear at the same edge
   assign cfgAck = (state == xbarCfgPkg::WaitRelease);

   assign cfg.sSel = selReg[nocChanPkg::South];
   assign cfg.wSel = selReg[nocChanPkg::West];
   assign cfg.nSel = selReg[nocChanPkg::North];
   assign cfg.eSel = selReg[nocChanPkg::East];
   assign cfg.lSel = selReg[nocChanPkg::Local];

endmodule

/* source/xbarCfgIf.sv */
`timescale 1ns/1ps

// stored source selection of the five crossbar outputs
interface xbarCfgIf;

   xbarCfgPkg::srcSelT sSel;   // source of south output
   xbarCfgPkg::srcSelT wSel;   // source of west output
   xbarCfgPkg::srcSelT nSel;   // source of north output
   xbarCfgPkg::srcSelT eSel;   // source of east output
   xbarCfgPkg::srcSelT lSel;   // source of local output

   // register bank side
   modport owner (
      output sSel,
      output wSel,
      output nSel,
      output eSel,
      output lSel
   );

   // data planes and ack return
   modport user (
      input sSel,
      input wSel,
      input nSel,
      input eSel,
      input lSel
   );

endinterface

/* source/xbarCfgPkg.sv */
package xbarCfgPkg;

   // one-hot source of one output, bit index is the source portT value
   // all zero means the output is disconnected
   typedef logic [nocChanPkg::PortCount-1:0] srcSelT;

   // legal turns under XY routing, indexed [output][source]
   // rows are listed local first because the array is packed
   localparam logic [nocChanPkg::PortCount-1:0][nocChanPkg::PortCount-1:0] TurnAllowed = {
      5'b01111,   // local: south, west, north, east
      5'b10111,   // east: south, west, north, local
      5'b10001,   // north: south, local
      5'b11101,   // west: south, north, east, local
      5'b10100    // south: north, local
   };

   // four-phase configuration port
   typedef enum logic [1:0] {
      Idle        = 2'd0,   // waiting for a request
      Write       = 2'd1,   // selection register gets loaded
      WaitRelease = 2'd2    // ack high until the request drops
   } cfgStateT;

   // selection code stored for a request
   // a forbidden turn or a disconnect both give zero
   function automatic srcSelT turnCode(
      input nocChanPkg::portT outPort,
      input nocChanPkg::portT srcPort,
      input logic             connect
   );
      srcSelT code;
      code = '0;
      if (connect && TurnAllowed[outPort][srcPort]) begin
         code[srcPort] = 1'b1;
      end
      return code;
   endfunction

endpackage

/* source/nocChanPkg.sv */
package nocChanPkg;

   // router geometry
   localparam int PortCount    = 5;   // south, west, north, east, local
   localparam int SubChanCount = 4;   // 8-bit channel as four 1-of-4 groups
   localparam int RailCount    = 4;   // rails of one 1-of-4 group

   // port order follows the XY mesh convention of the router
   typedef enum logic [2:0] {
      South = 3'd0,   // X+1
      West  = 3'd1,   // Y-1
      North = 3'd2,   // X-1
      East  = 3'd3,   // Y+1
      Local = 3'd4    // processing element
   } portT;

   // one 1-of-4 sub-channel, exactly one rail high for a valid symbol
   typedef logic [RailCount-1:0] quadT;

   // full channel payload, sub-channel 0 in the low quad
   typedef quadT [SubChanCount-1:0] chanDataT;

endpackage
